//--- filelist.f
source/soc_pkg.sv
source/axil_front.sv
source/bus_decode.sv
source/mem_bank.sv
source/soc_system_regs.sv
source/soc_gpio.sv
source/soc_top.sv
bench/soc_top_properties.sv
bench/tb_soc_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_soc_top
FILELIST  ?= filelist.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_soc_top.sv
/* directed testbench for soc_top. AXI4-Lite write and read tasks with
   response back-pressure, one task per behavior, cycle timeout */
`timescale 1ns/1ps

module tb_soc_top;

  localparam int MAX_CYCLES  = 2000;  // ~40 transactions of 12 cycles, reset, margin
  localparam int HOLD_CYCLES = 3;     // bready/rready held low this long

  logic                             sys_clk = 1'b0;
  logic                             rst_i;
  logic                             awvalid_i, awready_o, wvalid_i, wready_o;
  soc_pkg::addr_t                   awaddr_i, araddr_i;
  soc_pkg::data_t                   wdata_i, rdata_o;
  soc_pkg::strb_t                   wstrb_i;
  logic                             bvalid_o, bready_i, arvalid_i, arready_o;
  logic                             rvalid_o, rready_i;
  soc_pkg::resp_t                   bresp_o, rresp_o;
  soc_pkg::data_t                   gpio_pad_i, gpio_pad_o, gpio_padoe_o;
  logic [soc_pkg::BOOT_STRAP_W-1:0] boot_strap_i;

  integer                           seed;
  int                               cycle_cnt = 0;
  logic [soc_pkg::BOOT_STRAP_W-1:0] strap_at_reset;
  soc_pkg::data_t                   mem_model [int];  // expected memory words
  int                               word_idx [8];

  soc_top dut (
    .sys_clk (sys_clk), .rst_i (rst_i),
    .awvalid_i (awvalid_i), .awaddr_i (awaddr_i), .awready_o (awready_o),
    .wvalid_i (wvalid_i), .wdata_i (wdata_i), .wstrb_i (wstrb_i), .wready_o (wready_o),
    .bvalid_o (bvalid_o), .bresp_o (bresp_o), .bready_i (bready_i),
    .arvalid_i (arvalid_i), .araddr_i (araddr_i), .arready_o (arready_o),
    .rvalid_o (rvalid_o), .rdata_o (rdata_o), .rresp_o (rresp_o), .rready_i (rready_i),
    .gpio_pad_i (gpio_pad_i), .gpio_pad_o (gpio_pad_o), .gpio_padoe_o (gpio_padoe_o),
    .boot_strap_i (boot_strap_i)
  );

  always #2 sys_clk = ~sys_clk;  // 4 ns period

  always @(posedge sys_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic soc_pkg::addr_t region_addr(input logic [3:0] region,
                                                 input soc_pkg::addr_t offset);
    return {region, offset[27:0]};
  endfunction

  // ------------------------------------------------------------------------
  // bus tasks, called 1 ns after a rising edge
  task automatic axi_write(input soc_pkg::addr_t addr, input soc_pkg::data_t data,
                           input soc_pkg::strb_t strb, output soc_pkg::resp_t resp);
    awvalid_i = 1'b1;
    awaddr_i  = addr;
    wvalid_i  = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    @(negedge sys_clk);
    while (!(awready_o && wready_o))
      @(negedge sys_clk);
    @(posedge sys_clk);  // AW and W transfer here
    #1;
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    @(negedge sys_clk);
    while (!bvalid_o)
      @(negedge sys_clk);
    repeat (HOLD_CYCLES) @(negedge sys_clk);
    check_eq("bvalid_o", 32'(bvalid_o), 32'd1);  // held under back-pressure
    @(posedge sys_clk);
    #1;
    bready_i = 1'b1;
    @(negedge sys_clk);
    resp = bresp_o;
    @(posedge sys_clk);
    #1;
    bready_i = 1'b0;
  endtask

  task automatic axi_read(input soc_pkg::addr_t addr, output soc_pkg::data_t data,
                          output soc_pkg::resp_t resp);
    arvalid_i = 1'b1;
    araddr_i  = addr;
    @(negedge sys_clk);
    while (!arready_o)
      @(negedge sys_clk);
    @(posedge sys_clk);
    #1;
    arvalid_i = 1'b0;
    @(negedge sys_clk);
    while (!rvalid_o)
      @(negedge sys_clk);
    repeat (HOLD_CYCLES) @(negedge sys_clk);
    check_eq("rvalid_o", 32'(rvalid_o), 32'd1);
    @(posedge sys_clk);
    #1;
    rready_i = 1'b1;
    @(negedge sys_clk);
    data = rdata_o;
    resp = rresp_o;
    @(posedge sys_clk);
    #1;
    rready_i = 1'b0;
  endtask

  // ------------------------------------------------------------------------
  task automatic test_reset_state();
    soc_pkg::data_t rdata;
    soc_pkg::resp_t resp;
    @(negedge sys_clk);
    check_eq("gpio_pad_o", gpio_pad_o, 32'd0);
    check_eq("gpio_padoe_o", gpio_padoe_o, 32'd0);
    check_eq("bvalid_o", 32'(bvalid_o), 32'd0);
    check_eq("rvalid_o", 32'(rvalid_o), 32'd0);
    @(posedge sys_clk);
    #1;
    axi_read(region_addr(soc_pkg::REGION_SYS, soc_pkg::OFS_SYS_STRAP), rdata, resp);
    check_eq("rdata_o", rdata, 32'(strap_at_reset));
    check_eq("rresp_o", 32'(resp), 32'(soc_pkg::RESP_OKAY));
    boot_strap_i = ~strap_at_reset;  // pins move after reset, value stays frozen
    axi_read(region_addr(soc_pkg::REGION_SYS, soc_pkg::OFS_SYS_STRAP), rdata, resp);
    check_eq("rdata_o", rdata, 32'(strap_at_reset));
    axi_read(region_addr(soc_pkg::REGION_SYS, soc_pkg::OFS_SYS_ID), rdata, resp);
    check_eq("rdata_o", rdata, 32'h0120_0001);
  endtask

  task automatic test_memory();
    soc_pkg::data_t wdata;
    soc_pkg::data_t old;
    soc_pkg::data_t rdata;
    soc_pkg::resp_t resp;
    for (int i = 0; i < 8; i++) begin
      word_idx[i] = $random(seed) & (soc_pkg::MEM_WORDS - 1);
      wdata = $random(seed);
      axi_write(region_addr(soc_pkg::REGION_MEM, 32'(word_idx[i] * 4)), wdata, 4'hf, resp);
      check_eq("bresp_o", 32'(resp), 32'(soc_pkg::RESP_OKAY));
      mem_model[word_idx[i]] = wdata;  // a repeated index keeps the last word
    end
    for (int i = 0; i < 8; i++) begin
      axi_read(region_addr(soc_pkg::REGION_MEM, 32'(word_idx[i] * 4)), rdata, resp);
      check_eq("rdata_o", rdata, mem_model[word_idx[i]]);
      check_eq("rresp_o", 32'(resp), 32'(soc_pkg::RESP_OKAY));
    end
    // partial write, lanes 0 and 2 only
    old   = mem_model[word_idx[0]];
    wdata = $random(seed);
    axi_write(region_addr(soc_pkg::REGION_MEM, 32'(word_idx[0] * 4)), wdata, 4'h5, resp);
    check_eq("bresp_o", 32'(resp), 32'(soc_pkg::RESP_OKAY));
    mem_model[word_idx[0]] = {old[31:24], wdata[23:16], old[15:8], wdata[7:0]};
    axi_read(region_addr(soc_pkg::REGION_MEM, 32'(word_idx[0] * 4)), rdata, resp);
    check_eq("rdata_o", rdata, mem_model[word_idx[0]]);
    check_eq("rresp_o", 32'(resp), 32'(soc_pkg::RESP_OKAY));
  endtask

  task automatic test_scratch();
    soc_pkg::data_t wdata;
    soc_pkg::data_t rdata;
    soc_pkg::resp_t resp;
    wdata = $random(seed);
    axi_write(region_addr(soc_pkg::REGION_SYS, soc_pkg::OFS_SYS_SCRATCH), wdata, 4'hf, resp);
    check_eq("bresp_o", 32'(resp), 32'(soc_pkg::RESP_OKAY));
    axi_read(region_addr(soc_pkg::REGION_SYS, soc_pkg::OFS_SYS_SCRATCH), rdata, resp);
    check_eq("rdata_o", rdata, wdata);
    axi_write(region_addr(soc_pkg::REGION_SYS, soc_pkg::OFS_SYS_ID), ~wdata, 4'hf, resp);
    check_eq("bresp_o", 32'(resp), 32'(soc_pkg::RESP_OKAY));  // read-only, still okay
    axi_read(region_addr(soc_pkg::REGION_SYS, soc_pkg::OFS_SYS_ID), rdata, resp);
    check_eq("rdata_o", rdata, 32'h0120_0001);
  endtask

  task automatic test_gpio();
    soc_pkg::data_t out_val;
    soc_pkg::data_t oe_val;
    soc_pkg::data_t pad_val;
    soc_pkg::data_t rdata;
    soc_pkg::resp_t resp;
    out_val = $random(seed);
    oe_val  = $random(seed);
    pad_val = $random(seed);
    axi_write(region_addr(soc_pkg::REGION_GPIO, soc_pkg::OFS_GPIO_OUT), out_val, 4'hf, resp);
    check_eq("gpio_pad_o", gpio_pad_o, out_val);
    axi_write(region_addr(soc_pkg::REGION_GPIO, soc_pkg::OFS_GPIO_OE), oe_val, 4'hf, resp);
    check_eq("gpio_padoe_o", gpio_padoe_o, oe_val);
    gpio_pad_i = pad_val;
    repeat (3) @(posedge sys_clk);  // through the synchroniser
    #1;
    axi_read(region_addr(soc_pkg::REGION_GPIO, soc_pkg::OFS_GPIO_IN), rdata, resp);
    check_eq("rdata_o", rdata, pad_val);
    check_eq("rresp_o", 32'(resp), 32'(soc_pkg::RESP_OKAY));
  endtask

  task automatic test_unmapped();
    soc_pkg::data_t rdata;
    soc_pkg::resp_t resp;
    axi_write(region_addr(4'h7, 32'(word_idx[1] * 4)), $random(seed), 4'hf, resp);
    check_eq("bresp_o", 32'(resp), 32'(soc_pkg::RESP_SLVERR));
    axi_read(region_addr(4'h7, 32'(word_idx[1] * 4)), rdata, resp);
    check_eq("rresp_o", 32'(resp), 32'(soc_pkg::RESP_SLVERR));
    check_eq("rdata_o", rdata, 32'd0);
    axi_read(region_addr(soc_pkg::REGION_MEM, 32'(word_idx[1] * 4)), rdata, resp);
    check_eq("rdata_o", rdata, mem_model[word_idx[1]]);  // bank untouched
  endtask

  // ------------------------------------------------------------------------
  initial begin
    seed           = 32'hef93adc2;
    rst_i          = 1'b1;
    awvalid_i      = 1'b0;
    awaddr_i       = '0;
    wvalid_i       = 1'b0;
    wdata_i        = '0;
    wstrb_i        = '0;
    bready_i       = 1'b0;
    arvalid_i      = 1'b0;
    araddr_i       = '0;
    rready_i       = 1'b0;
    gpio_pad_i     = '0;
    strap_at_reset = 4'($random(seed));
    boot_strap_i   = strap_at_reset;
    repeat (16) @(posedge sys_clk);
    #1;
    rst_i = 1'b0;
    test_reset_state();
    test_memory();
    test_scratch();
    test_gpio();
    test_unmapped();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- bench/soc_top_properties.sv
/* concurrent assertions on the AXI response channels of soc_top,
   bound into every soc_top instance */
`timescale 1ns/1ps

module soc_top_properties (
  input logic           sys_clk,
  input logic           rst_i,
  input logic           awvalid_i,
  input logic           awready_i,
  input logic           wvalid_i,
  input logic           wready_i,
  input logic           arvalid_i,
  input logic           arready_i,
  input logic           bvalid_i,
  input logic           bready_i,
  input soc_pkg::resp_t bresp_i,
  input logic           rvalid_i,
  input logic           rready_i,
  input soc_pkg::data_t rdata_i
);

  logic accepted;

  assign accepted = (awvalid_i && awready_i && wvalid_i && wready_i) ||
                    (arvalid_i && arready_i);

  b_hold: assert property (@(posedge sys_clk) disable iff (rst_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else $error("bvalid dropped or bresp changed before bready");

  r_hold: assert property (@(posedge sys_clk) disable iff (rst_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else $error("rvalid dropped or rdata changed before rready");

  one_rsp: assert property (@(posedge sys_clk) disable iff (rst_i)
    !(bvalid_i && rvalid_i))
    else $error("bvalid and rvalid high together");

  // accept edge to response edge is four cycles
  // the rise shows in the samples one edge later
  rsp_latency: assert property (@(posedge sys_clk) disable iff (rst_i)
    accepted |=> ##4 $rose(bvalid_i || rvalid_i))
    else $error("response did not rise 4 cycles after accept");

endmodule

bind soc_top soc_top_properties u_soc_top_properties (
  .sys_clk   (sys_clk),   .rst_i     (rst_i),
  .awvalid_i (awvalid_i), .awready_i (awready_o),
  .wvalid_i  (wvalid_i),  .wready_i  (wready_o),
  .arvalid_i (arvalid_i), .arready_i (arready_o),
  .bvalid_i  (bvalid_o),  .bready_i  (bready_i),  .bresp_i (bresp_o),
  .rvalid_i  (rvalid_o),  .rready_i  (rready_i),  .rdata_i (rdata_o)
);

//--- source/soc_top.sv
/* top level: AXI4-Lite front end, decode stage and the three slaves,
   with the AXI channels and the pads brought out */
`timescale 1ns/1ps

module soc_top (
  input  logic                              sys_clk,
  input  logic                              rst_i,
  input  logic                              awvalid_i,
  input  soc_pkg::addr_t                    awaddr_i,
  output logic                              awready_o,
  input  logic                              wvalid_i,
  input  soc_pkg::data_t                    wdata_i,
  input  soc_pkg::strb_t                    wstrb_i,
  output logic                              wready_o,
  output logic                              bvalid_o,
  output soc_pkg::resp_t                    bresp_o,
  input  logic                              bready_i,
  input  logic                              arvalid_i,
  input  soc_pkg::addr_t                    araddr_i,
  output logic                              arready_o,
  output logic                              rvalid_o,
  output soc_pkg::data_t                    rdata_o,
  output soc_pkg::resp_t                    rresp_o,
  input  logic                              rready_i,
  input  soc_pkg::data_t                    gpio_pad_i,
  output soc_pkg::data_t                    gpio_pad_o,
  output soc_pkg::data_t                    gpio_padoe_o,
  input  logic [soc_pkg::BOOT_STRAP_W-1:0]  boot_strap_i
);

  // front end to decode
  logic           req_valid, req_we;
  soc_pkg::addr_t req_addr;
  soc_pkg::data_t req_wdata;
  soc_pkg::strb_t req_strb;
  logic           rsp_valid;
  soc_pkg::data_t rsp_rdata;
  soc_pkg::resp_t rsp_resp;

  // decode to slaves, shared payload
  logic           slv_we;
  soc_pkg::addr_t slv_addr;
  soc_pkg::data_t slv_wdata;
  soc_pkg::strb_t slv_strb;
  logic           mem_stb, sys_stb, gpio_stb;
  logic           mem_ack, sys_ack, gpio_ack;
  soc_pkg::data_t mem_rdata, sys_rdata, gpio_rdata;

  // --------------------------------------------------------------------------
  axil_front i_axil_front (
    .sys_clk     (sys_clk),     .rst_i       (rst_i),
    .awvalid_i   (awvalid_i),   .awaddr_i    (awaddr_i),    .awready_o   (awready_o),
    .wvalid_i    (wvalid_i),    .wdata_i     (wdata_i),     .wstrb_i     (wstrb_i),
    .wready_o    (wready_o),
    .bvalid_o    (bvalid_o),    .bresp_o     (bresp_o),     .bready_i    (bready_i),
    .arvalid_i   (arvalid_i),   .araddr_i    (araddr_i),    .arready_o   (arready_o),
    .rvalid_o    (rvalid_o),    .rdata_o     (rdata_o),     .rresp_o     (rresp_o),
    .rready_i    (rready_i),
    .req_valid_o (req_valid),   .req_we_o    (req_we),      .req_addr_o  (req_addr),
    .req_wdata_o (req_wdata),   .req_strb_o  (req_strb),
    .rsp_valid_i (rsp_valid),   .rsp_rdata_i (rsp_rdata),   .rsp_resp_i  (rsp_resp)
  );

  bus_decode i_bus_decode (
    .sys_clk      (sys_clk),    .rst_i        (rst_i),
    .req_valid_i  (req_valid),  .req_we_i     (req_we),     .req_addr_i   (req_addr),
    .req_wdata_i  (req_wdata),  .req_strb_i   (req_strb),
    .mem_stb_o    (mem_stb),    .sys_stb_o    (sys_stb),    .gpio_stb_o   (gpio_stb),
    .slv_we_o     (slv_we),     .slv_addr_o   (slv_addr),
    .slv_wdata_o  (slv_wdata),  .slv_strb_o   (slv_strb),
    .mem_ack_i    (mem_ack),    .mem_rdata_i  (mem_rdata),
    .sys_ack_i    (sys_ack),    .sys_rdata_i  (sys_rdata),
    .gpio_ack_i   (gpio_ack),   .gpio_rdata_i (gpio_rdata),
    .rsp_valid_o  (rsp_valid),  .rsp_rdata_o  (rsp_rdata),  .rsp_resp_o   (rsp_resp)
  );

  // --------------------------------------------------------------------------
  mem_bank #(.WORDS(soc_pkg::MEM_WORDS)) i_mem_bank (
    .sys_clk (sys_clk),   .rst_i   (rst_i),
    .stb_i   (mem_stb),   .we_i    (slv_we),    .addr_i  (slv_addr),
    .wdata_i (slv_wdata), .strb_i  (slv_strb),
    .ack_o   (mem_ack),   .rdata_o (mem_rdata)
  );

  soc_system_regs i_soc_system_regs (
    .sys_clk      (sys_clk),      .rst_i   (rst_i),
    .boot_strap_i (boot_strap_i),
    .stb_i        (sys_stb),      .we_i    (slv_we),    .addr_i  (slv_addr),
    .wdata_i      (slv_wdata),    .strb_i  (slv_strb),
    .ack_o        (sys_ack),      .rdata_o (sys_rdata)
  );

  soc_gpio i_soc_gpio (
    .sys_clk      (sys_clk),      .rst_i        (rst_i),
    .stb_i        (gpio_stb),     .we_i         (slv_we),     .addr_i  (slv_addr),
    .wdata_i      (slv_wdata),    .strb_i       (slv_strb),
    .gpio_pad_i   (gpio_pad_i),
    .ack_o        (gpio_ack),     .rdata_o      (gpio_rdata),
    .gpio_pad_o   (gpio_pad_o),   .gpio_padoe_o (gpio_padoe_o)
  );

endmodule

//--- source/soc_gpio.sv
/* single GPIO port: output and output-enable registers driving the pads,
   pad input through a two-flop synchroniser */
`timescale 1ns/1ps

module soc_gpio (
  input  logic             sys_clk,
  input  logic             rst_i,
  input  logic             stb_i,
  input  logic             we_i,
  input  soc_pkg::addr_t   addr_i,
  input  soc_pkg::data_t   wdata_i,
  input  soc_pkg::strb_t   strb_i,
  input  soc_pkg::data_t   gpio_pad_i,
  output logic             ack_o,
  output soc_pkg::data_t   rdata_o,
  output soc_pkg::data_t   gpio_pad_o,
  output soc_pkg::data_t   gpio_padoe_o
);

  soc_pkg::data_t in_meta_q;
  soc_pkg::data_t in_sync_q;
  logic           wr;

  assign wr = stb_i && we_i;

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      gpio_pad_o   <= '0;
      gpio_padoe_o <= '0;  // pads float out of reset
      ack_o        <= 1'b0;
    end else begin
      ack_o <= stb_i;
      if (wr && addr_i[27:2] == soc_pkg::OFS_GPIO_OUT[27:2])
        gpio_pad_o <= soc_pkg::merge_bytes(gpio_pad_o, wdata_i, strb_i);
      if (wr && addr_i[27:2] == soc_pkg::OFS_GPIO_OE[27:2])
        gpio_padoe_o <= soc_pkg::merge_bytes(gpio_padoe_o, wdata_i, strb_i);
    end
  end

  // pad input synchroniser
  always_ff @(posedge sys_clk) begin
    in_meta_q <= gpio_pad_i;
    in_sync_q <= in_meta_q;
  end

  always_ff @(posedge sys_clk) begin
    if (stb_i) begin
      case (addr_i[27:2])
        soc_pkg::OFS_GPIO_OUT[27:2]: rdata_o <= gpio_pad_o;
        soc_pkg::OFS_GPIO_OE[27:2]:  rdata_o <= gpio_padoe_o;
        soc_pkg::OFS_GPIO_IN[27:2]:  rdata_o <= in_sync_q;
        default:                     rdata_o <= '0;
      endcase
    end
  end

endmodule

//--- source/soc_system_regs.sv
/* system register block: boot strap value latched while in reset,
   chip identifier and a byte-writable scratch register */
`timescale 1ns/1ps

module soc_system_regs (
  input  logic                              sys_clk,
  input  logic                              rst_i,
  input  logic [soc_pkg::BOOT_STRAP_W-1:0]  boot_strap_i,
  input  logic                              stb_i,
  input  logic                              we_i,
  input  soc_pkg::addr_t                    addr_i,
  input  soc_pkg::data_t                    wdata_i,
  input  soc_pkg::strb_t                    strb_i,
  output logic                              ack_o,
  output soc_pkg::data_t                    rdata_o
);

  logic [soc_pkg::BOOT_STRAP_W-1:0] strap_q;
  soc_pkg::data_t                   scratch_q;

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      strap_q   <= boot_strap_i;   // follows the pins until reset ends
      scratch_q <= '0;
      ack_o     <= 1'b0;
    end else begin
      ack_o <= stb_i;
      if (stb_i && we_i && addr_i[27:2] == soc_pkg::OFS_SYS_SCRATCH[27:2])
        scratch_q <= soc_pkg::merge_bytes(scratch_q, wdata_i, strb_i);
    end
  end

  // read mux, unknown offsets give zero
  always_ff @(posedge sys_clk) begin
    if (stb_i) begin
      case (addr_i[27:2])
        soc_pkg::OFS_SYS_STRAP[27:2]:   rdata_o <= soc_pkg::data_t'(strap_q);
        soc_pkg::OFS_SYS_ID[27:2]:      rdata_o <= soc_pkg::SOC_ID;
        soc_pkg::OFS_SYS_SCRATCH[27:2]: rdata_o <= scratch_q;
        default:                        rdata_o <= '0;
      endcase
    end
  end

endmodule

//--- source/mem_bank.sv
/* on-chip word memory, byte write strobes, registered read.
   depth is any power of two, addresses wrap */
`timescale 1ns/1ps

module mem_bank #(
  parameter int WORDS = soc_pkg::MEM_WORDS
) (
  input  logic             sys_clk,
  input  logic             rst_i,
  input  logic             stb_i,
  input  logic             we_i,
  input  soc_pkg::addr_t   addr_i,
  input  soc_pkg::data_t   wdata_i,
  input  soc_pkg::strb_t   strb_i,
  output logic             ack_o,
  output soc_pkg::data_t   rdata_o
);

  soc_pkg::data_t             mem [WORDS];
  logic [$clog2(WORDS)-1:0]   idx;

  assign idx = addr_i[$clog2(WORDS)+1:2];  // word index, upper bits dropped

  always_ff @(posedge sys_clk) begin
    if (stb_i) begin
      if (we_i)
        mem[idx] <= soc_pkg::merge_bytes(mem[idx], wdata_i, strb_i);
      rdata_o <= mem[idx];                 // old word on a write
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rst_i)
      ack_o <= 1'b0;
    else
      ack_o <= stb_i;
  end

endmodule

//--- source/bus_decode.sv
/* registered address decode stage, one strobe per slave region,
   error answer for unmapped addresses and response steering */
`timescale 1ns/1ps

module bus_decode (
  input  logic             sys_clk,
  input  logic             rst_i,
  input  logic             req_valid_i,
  input  logic             req_we_i,
  input  soc_pkg::addr_t   req_addr_i,
  input  soc_pkg::data_t   req_wdata_i,
  input  soc_pkg::strb_t   req_strb_i,
  output logic             mem_stb_o,
  output logic             sys_stb_o,
  output logic             gpio_stb_o,
  output logic             slv_we_o,
  output soc_pkg::addr_t   slv_addr_o,
  output soc_pkg::data_t   slv_wdata_o,
  output soc_pkg::strb_t   slv_strb_o,
  input  logic             mem_ack_i,
  input  soc_pkg::data_t   mem_rdata_i,
  input  logic             sys_ack_i,
  input  soc_pkg::data_t   sys_rdata_i,
  input  logic             gpio_ack_i,
  input  soc_pkg::data_t   gpio_rdata_i,
  output logic             rsp_valid_o,
  output soc_pkg::data_t   rsp_rdata_o,
  output soc_pkg::resp_t   rsp_resp_o
);

  logic [3:0] region;
  logic       hit_mem;
  logic       hit_sys;
  logic       hit_gpio;
  logic       miss_q;      // unmapped, in the stb cycle
  logic       miss_rsp_q;  // unmapped, in the response cycle

  assign region   = req_addr_i[31:28];
  assign hit_mem  = (region == soc_pkg::REGION_MEM);
  assign hit_sys  = (region == soc_pkg::REGION_SYS);
  assign hit_gpio = (region == soc_pkg::REGION_GPIO);

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      mem_stb_o  <= 1'b0;
      sys_stb_o  <= 1'b0;
      gpio_stb_o <= 1'b0;
      miss_q     <= 1'b0;
      miss_rsp_q <= 1'b0;
    end else begin
      mem_stb_o  <= req_valid_i && hit_mem;
      sys_stb_o  <= req_valid_i && hit_sys;
      gpio_stb_o <= req_valid_i && hit_gpio;
      miss_q     <= req_valid_i && !(hit_mem || hit_sys || hit_gpio);
      miss_rsp_q <= miss_q;    // answer where a slave would ack
    end
  end

  always_ff @(posedge sys_clk) begin
    if (req_valid_i) begin
      slv_we_o    <= req_we_i;
      slv_addr_o  <= req_addr_i;
      slv_wdata_o <= req_wdata_i;
      slv_strb_o  <= req_strb_i;
    end
  end

  // only one slave acks at a time
  always_comb begin
    rsp_valid_o = mem_ack_i || sys_ack_i || gpio_ack_i || miss_rsp_q;
    rsp_resp_o  = miss_rsp_q ? soc_pkg::RESP_SLVERR : soc_pkg::RESP_OKAY;
    rsp_rdata_o = '0;
    if (mem_ack_i)
      rsp_rdata_o = mem_rdata_i;
    else if (sys_ack_i)
      rsp_rdata_o = sys_rdata_i;
    else if (gpio_ack_i)
      rsp_rdata_o = gpio_rdata_i;
  end

endmodule

//--- source/axil_front.sv
/* AXI4-Lite slave port. Takes one write or read at a time, passes it on as
   a single request pulse and holds the response on B or R until taken */
`timescale 1ns/1ps

module axil_front (
  input  logic             sys_clk,
  input  logic             rst_i,
  // AXI4-Lite
  input  logic             awvalid_i,
  input  soc_pkg::addr_t   awaddr_i,
  output logic             awready_o,
  input  logic             wvalid_i,
  input  soc_pkg::data_t   wdata_i,
  input  soc_pkg::strb_t   wstrb_i,
  output logic             wready_o,
  output logic             bvalid_o,
  output soc_pkg::resp_t   bresp_o,
  input  logic             bready_i,
  input  logic             arvalid_i,
  input  soc_pkg::addr_t   araddr_i,
  output logic             arready_o,
  output logic             rvalid_o,
  output soc_pkg::data_t   rdata_o,
  output soc_pkg::resp_t   rresp_o,
  input  logic             rready_i,
  // internal request
  output logic             req_valid_o,
  output logic             req_we_o,
  output soc_pkg::addr_t   req_addr_o,
  output soc_pkg::data_t   req_wdata_o,
  output soc_pkg::strb_t   req_strb_o,
  // internal response
  input  logic             rsp_valid_i,
  input  soc_pkg::data_t   rsp_rdata_i,
  input  soc_pkg::resp_t   rsp_resp_i
);

  soc_pkg::front_state_e state_q;
  logic                  wr_acc;
  logic                  rd_acc;
  logic                  rsp_taken;

  // writes win when both are pending
  assign wr_acc = (state_q == soc_pkg::IDLE) && awvalid_i && wvalid_i;
  assign rd_acc = (state_q == soc_pkg::IDLE) && arvalid_i && !(awvalid_i && wvalid_i);

  assign awready_o = wr_acc;
  assign wready_o  = wr_acc;
  assign arready_o = rd_acc;

  assign rsp_taken = (bvalid_o && bready_i) || (rvalid_o && rready_i);

  // --------------------------------------------------------------------------
  // control
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      state_q     <= soc_pkg::IDLE;
      req_valid_o <= 1'b0;
      bvalid_o    <= 1'b0;
      rvalid_o    <= 1'b0;
    end else begin
      req_valid_o <= 1'b0;
      case (state_q)
        soc_pkg::IDLE: begin
          if (wr_acc || rd_acc)
            state_q <= soc_pkg::REQ;
        end
        soc_pkg::REQ: begin
          req_valid_o <= 1'b1;         // request leaves one cycle after accept
          state_q     <= soc_pkg::RESP;
        end
        soc_pkg::RESP: begin
          if (rsp_valid_i) begin
            bvalid_o <= req_we_o;
            rvalid_o <= !req_we_o;
          end
          if (rsp_taken) begin
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
            state_q  <= soc_pkg::IDLE;
          end
        end
        default: state_q <= soc_pkg::IDLE;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // request and response payload
  always_ff @(posedge sys_clk) begin
    if (wr_acc) begin
      req_we_o    <= 1'b1;
      req_addr_o  <= awaddr_i;
      req_wdata_o <= wdata_i;
      req_strb_o  <= wstrb_i;
    end else if (rd_acc) begin
      req_we_o    <= 1'b0;
      req_addr_o  <= araddr_i;
      req_wdata_o <= '0;
      req_strb_o  <= '0;               // reads carry no strobes
    end
    if (state_q == soc_pkg::RESP && rsp_valid_i) begin
      bresp_o <= rsp_resp_i;
      rresp_o <= rsp_resp_i;
      rdata_o <= rsp_rdata_i;
    end
  end

endmodule

//--- source/soc_pkg.sv
/* shared definitions for the system bus: address map, bus widths,
   response codes and the front end state type */
package soc_pkg;

  typedef logic [31:0] addr_t;  // byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;  // one bit per data byte
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // address bits 31:28 pick the slave
  localparam logic [3:0] REGION_MEM  = 4'h0;
  localparam logic [3:0] REGION_SYS  = 4'h4;
  localparam logic [3:0] REGION_GPIO = 4'h5;

  localparam int MEM_IDX_W = 10;
  localparam int MEM_WORDS = 2 ** MEM_IDX_W;  // 4 KiB

  localparam data_t SOC_ID       = 32'h0120_0001;
  localparam int    BOOT_STRAP_W = 4;

  localparam addr_t OFS_SYS_STRAP   = 32'h0;
  localparam addr_t OFS_SYS_ID      = 32'h4;
  localparam addr_t OFS_SYS_SCRATCH = 32'h8;

  localparam addr_t OFS_GPIO_OUT = 32'h0;
  localparam addr_t OFS_GPIO_OE  = 32'h4;
  localparam addr_t OFS_GPIO_IN  = 32'h8;

  typedef enum logic [1:0] {IDLE, REQ, RESP} front_state_e;

  // byte lanes of wdata replace those of cur where strb is set
  function automatic data_t merge_bytes(data_t cur, data_t wdata, strb_t strb);
    data_t res;
    res = cur;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (strb[b])
        res[b*8 +: 8] = wdata[b*8 +: 8];
    end
    return res;
  endfunction

endpackage
